// File: Makefile
# Verilator simulation of the machine-mode privileged unit
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TB_TOP    ?= priv_block_tb
FILELIST  ?= priv_block.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: priv_block.f
verilog/priv_pkg.sv
verilog/priv_csr_decode.sv
verilog/priv_csr_file.sv
verilog/priv_trap_handler.sv
verilog/priv_block.sv
sim/priv_block_tb.sv

// File: sim/priv_block_patterns.txt
# One operation per line, fields in hex. W addr op(1 swap, 2 set, 3 clear) data invalid
# R addr rdata | E flags epc badaddr pc mcause | I levels(mip bits) pc mcause | M pc | T count
R 305 00000100
R 301 40000100
R F14 00000000
R 300 00000000
R 341 00000000
R 342 00000000
W 340 1 12345678 0
W 340 2 0000F00F 0
R 340 1234F67F
W 340 3 00000670 0
R 340 1234F00F
W 304 1 00000C0C 0
W 304 3 00000404 0
R 304 00000808
W 7C0 1 FFFFFFFF 1
W F14 1 DEADBEEF 1
R F14 00000000
W 305 1 00000201 0
W 300 2 00000008 0
E 0D0 80001000 40000003 00000200 00000006
R 341 80001000
R 343 40000003
R 300 00000080
M 80001000
R 300 00000088
W 304 2 00000080 0
I 888 0000022C 8000000B
M 80001000
I 088 0000020C 80000003
M 80001000
I 080 0000021C 80000007
W 300 3 00000008 0
I 888 FFFFFFFF 80000007
E 10C 80002000 00001234 00000200 00000003
R 343 00000000
R 300 00000000
M 80002000
R 300 00000080
T 5
R B02 00000005

// File: sim/priv_block_tb.sv
/*
 * Testbench for the machine-mode privileged unit
 * Replays the pattern file and checks CSR reads, illegal flags and redirects
 */

`timescale 1ns/1ps

module priv_block_tb;

    localparam int          RESET_CYCLES  = 16;
    localparam int          REDIRECT_WAIT = 4;
    localparam string       PATTERN_FILE  = "sim/priv_block_patterns.txt";
    // Expected pc that marks a case where no redirect may happen
    localparam logic [31:0] NO_REDIRECT   = 32'hFFFF_FFFF;

    logic        clk;
    logic        reset;
    logic [11:0] csr_addr;
    logic        swap;
    logic        set;
    logic        clr;
    logic [31:0] wdata;
    logic        valid_write;
    logic        instr;
    logic        wb_enable;
    logic        mal_insn;
    logic        fault_insn;
    logic        illegal_insn;
    logic        breakpoint;
    logic        mal_l;
    logic        fault_l;
    logic        mal_s;
    logic        fault_s;
    logic        env;
    logic [31:0] epc;
    logic [31:0] badaddr;
    logic        ret;
    logic        timer_int;
    logic        soft_int;
    logic        ext_int;
    logic [31:0] rdata;
    logic        invalid_priv_isn;
    logic [31:0] priv_pc;
    logic        insert_pc;
    logic        intr;

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    cycle_limit = 0;
    string lines[$];

    priv_block #(.HART_ID(32'h0), .MTVEC_RESET(32'h100)) dut0 (
        .CLK(clk), .reset(reset), .csr_addr(csr_addr), .swap(swap), .set(set), .clr(clr),
        .wdata(wdata), .valid_write(valid_write), .instr(instr), .wb_enable(wb_enable),
        .mal_insn(mal_insn), .fault_insn(fault_insn), .illegal_insn(illegal_insn),
        .breakpoint(breakpoint), .mal_l(mal_l), .fault_l(fault_l), .mal_s(mal_s),
        .fault_s(fault_s), .env(env), .epc(epc), .badaddr(badaddr), .ret(ret),
        .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
        .rdata(rdata), .invalid_priv_isn(invalid_priv_isn), .priv_pc(priv_pc),
        .insert_pc(insert_pc), .intr(intr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    // Inputs change shortly after the rising edge
    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_csr(input logic [11:0] addr, input logic [31:0] exp);
        csr_addr    = addr;
        valid_write = 1'b0;
        #1;
        compare_word($sformatf("rdata at csr %h", addr), rdata, exp);
    endtask

    task automatic do_write(input logic [11:0] addr, input logic [1:0] op,
                            input logic [31:0] data, input logic exp_inv);
        csr_addr    = addr;
        wdata       = data;
        valid_write = 1'b1;
        swap        = (op == 2'd1);
        set         = (op == 2'd2);
        clr         = (op == 2'd3);
        #1;
        compare_word("invalid_priv_isn", {31'b0, invalid_priv_isn}, {31'b0, exp_inv});
        step();
        valid_write = 1'b0;
        swap        = 1'b0;
        set         = 1'b0;
        clr         = 1'b0;
    endtask

    // Called just after the edge where the trap or mret should be taken
    task automatic check_redirect(input logic [31:0] exp_pc, input logic exp_intr,
                                  input logic [31:0] exp_cause, input logic read_cause);
        int waited;
        waited = 0;
        while (!insert_pc && waited < REDIRECT_WAIT) begin
            step();
            waited++;
        end
        checks++;
        if (exp_pc == NO_REDIRECT) begin
            if (insert_pc) begin
                $display("Unexpected redirect to %h while interrupts are disabled", priv_pc);
                errors++;
            end
        end else if (!insert_pc) begin
            $display("No redirect seen within %0d cycles", REDIRECT_WAIT + 1);
            errors++;
        end else begin
            if (waited != 0) begin
                $display("Redirect came %0d cycles later than the next cycle", waited);
                errors++;
            end
            compare_word("priv_pc", priv_pc, exp_pc);
            compare_word("intr", {31'b0, intr}, {31'b0, exp_intr});
        end
        if (read_cause) begin
            check_csr(12'h342, exp_cause);
        end
        step();
        if (exp_pc != NO_REDIRECT && insert_pc) begin
            $display("insert_pc stayed high for more than one cycle");
            errors++;
        end
    endtask

    task automatic run_line(input string line);
        byte         kind;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        int          n;
        n = $sscanf(line, "%c %h %h %h %h %h", kind, f0, f1, f2, f3, f4);
        case (kind)
            "W": do_write(f0[11:0], f1[1:0], f2, f3[0]);
            "R": begin
                check_csr(f0[11:0], f1);
                step();
            end
            "E": begin
                {env, fault_s, mal_s, fault_l, mal_l, breakpoint, illegal_insn,
                    fault_insn, mal_insn} = f0[8:0];
                epc     = f1;
                badaddr = f2;
                step();
                {env, fault_s, mal_s, fault_l, mal_l, breakpoint, illegal_insn,
                    fault_insn, mal_insn} = 9'b0;
                check_redirect(f3, 1'b0, f4, 1'b1);
            end
            "I": begin
                // Levels use the mip bit layout, epc keeps its last value
                soft_int  = f0[3];
                timer_int = f0[7];
                ext_int   = f0[11];
                step();
                soft_int  = 1'b0;
                timer_int = 1'b0;
                ext_int   = 1'b0;
                check_redirect(f1, 1'b1, f2, 1'b1);
            end
            "M": begin
                ret = 1'b1;
                step();
                ret = 1'b0;
                check_redirect(f0, 1'b0, 32'h0, 1'b0);
            end
            "T": begin
                repeat (f0) begin
                    instr     = 1'b1;
                    wb_enable = 1'b1;
                    step();
                end
                instr     = 1'b0;
                wb_enable = 1'b0;
            end
            default: begin
                $display("Pattern line not understood (%0d fields): %s", n, line);
                errors++;
            end
        endcase
    endtask

    task automatic load_patterns();
        int    fd;
        string text;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open pattern file %s", PATTERN_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                text = "";
                if ($fgets(text, fd) > 0 && text.len() > 1 && text[0] != "#") begin
                    lines.push_back(text);
                end
            end
            $fclose(fd);
            if (lines.size() == 0) begin
                $display("Pattern file %s holds no operations", PATTERN_FILE);
                errors++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        csr_addr     = 12'h0;
        swap         = 1'b0;
        set          = 1'b0;
        clr          = 1'b0;
        wdata        = 32'h0;
        valid_write  = 1'b0;
        instr        = 1'b0;
        wb_enable    = 1'b0;
        {env, fault_s, mal_s, fault_l, mal_l, breakpoint, illegal_insn,
            fault_insn, mal_insn} = 9'b0;
        epc          = 32'h0;
        badaddr      = 32'h0;
        ret          = 1'b0;
        timer_int    = 1'b0;
        soft_int     = 1'b0;
        ext_int      = 1'b0;
        load_patterns();
        cycle_limit = 8 * lines.size() + 100;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        reset = 1'b0;
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        $display("Pattern lines: %0d, checks: %0d, errors: %0d",
                 lines.size(), checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog/priv_block.sv
/*
 * Machine-mode privileged unit top level
 * Connects CSR decode, CSR file and trap handler to the pipeline
 */

`timescale 1ns/1ps

module priv_block #(
    parameter logic [31:0] HART_ID     = 32'h0,
    parameter logic [31:0] MTVEC_RESET = 32'h100
) (
    input  logic                      CLK,
    input  logic                      reset,
    // CSR request
    input  logic [11:0]               csr_addr,
    input  logic                      swap,
    input  logic                      set,
    input  logic                      clr,
    input  logic [priv_pkg::XLEN-1:0] wdata,
    input  logic                      valid_write,
    // Retire
    input  logic                      instr,
    input  logic                      wb_enable,
    // Exceptions
    input  logic                      mal_insn,
    input  logic                      fault_insn,
    input  logic                      illegal_insn,
    input  logic                      breakpoint,
    input  logic                      mal_l,
    input  logic                      fault_l,
    input  logic                      mal_s,
    input  logic                      fault_s,
    input  logic                      env,
    input  logic [priv_pkg::XLEN-1:0] epc,
    input  logic [priv_pkg::XLEN-1:0] badaddr,
    input  logic                      ret,
    // Interrupt levels
    input  logic                      timer_int,
    input  logic                      soft_int,
    input  logic                      ext_int,
    // To pipeline
    output logic [priv_pkg::XLEN-1:0] rdata,
    output logic                      invalid_priv_isn,
    output logic [priv_pkg::XLEN-1:0] priv_pc,
    output logic                      insert_pc,
    output logic                      intr
);

    priv_pkg::csr_op_e         csr_op;
    priv_pkg::csr_addr_e       csr_sel;
    logic                      invalid_csr;
    logic                      mstatus_mie;
    logic [priv_pkg::XLEN-1:0] mie_bits;
    logic [priv_pkg::XLEN-1:0] mtvec_val;
    logic [priv_pkg::XLEN-1:0] mepc_val;
    logic                      trap_take;
    priv_pkg::cause_e          trap_cause;
    logic                      trap_intr;
    logic [priv_pkg::XLEN-1:0] trap_epc;
    logic [priv_pkg::XLEN-1:0] trap_tval;
    logic                      mret_take;

    assign invalid_priv_isn = invalid_csr;

    priv_csr_decode csr_decode (
        .csr_addr(csr_addr), .swap(swap), .set(set), .clr(clr),
        .valid_write(valid_write), .csr_op(csr_op), .csr_sel(csr_sel),
        .invalid_csr(invalid_csr)
    );

    priv_csr_file #(.HART_ID(HART_ID), .MTVEC_RESET(MTVEC_RESET)) csr_file (
        .CLK(CLK), .reset(reset), .csr_op(csr_op), .csr_sel(csr_sel),
        .invalid_csr(invalid_csr), .wdata(wdata), .instr(instr), .wb_enable(wb_enable),
        .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
        .trap_take(trap_take), .trap_cause(trap_cause), .trap_intr(trap_intr),
        .trap_epc(trap_epc), .trap_tval(trap_tval), .mret_take(mret_take),
        .rdata(rdata), .mstatus_mie(mstatus_mie), .mie_bits(mie_bits),
        .mtvec_val(mtvec_val), .mepc_val(mepc_val)
    );

    priv_trap_handler trap_handler (
        .CLK(CLK), .reset(reset),
        .mal_insn(mal_insn), .fault_insn(fault_insn), .illegal_insn(illegal_insn),
        .breakpoint(breakpoint), .mal_l(mal_l), .fault_l(fault_l),
        .mal_s(mal_s), .fault_s(fault_s), .env(env),
        .epc(epc), .badaddr(badaddr), .ret(ret),
        .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
        .mstatus_mie(mstatus_mie), .mie_bits(mie_bits),
        .mtvec_val(mtvec_val), .mepc_val(mepc_val),
        .trap_take(trap_take), .trap_cause(trap_cause), .trap_intr(trap_intr),
        .trap_epc(trap_epc), .trap_tval(trap_tval), .mret_take(mret_take),
        .priv_pc(priv_pc), .insert_pc(insert_pc), .intr(intr)
    );

endmodule

// File: verilog/priv_csr_decode.sv
/*
 * CSR request decode
 * Turns the address and strobes into an operation, a register select
 * and a legality flag
 */

`timescale 1ns/1ps

module priv_csr_decode (
    input  logic [11:0]         csr_addr,
    input  logic                swap,
    input  logic                set,
    input  logic                clr,
    input  logic                valid_write,
    output priv_pkg::csr_op_e   csr_op,
    output priv_pkg::csr_addr_e csr_sel,
    output logic                invalid_csr
);

    logic known;
    logic read_only;
    logic strobe;

    assign strobe  = swap | set | clr;
    assign csr_sel = priv_pkg::csr_addr_e'(csr_addr);

    // Address lookup
    always_comb begin
        known     = 1'b1;
        read_only = 1'b0;
        case (csr_addr)
            priv_pkg::CSR_MISA,
            priv_pkg::CSR_MIP,
            priv_pkg::CSR_MHARTID: read_only = 1'b1;
            priv_pkg::CSR_MSTATUS,
            priv_pkg::CSR_MIE,
            priv_pkg::CSR_MTVEC,
            priv_pkg::CSR_MSCRATCH,
            priv_pkg::CSR_MEPC,
            priv_pkg::CSR_MCAUSE,
            priv_pkg::CSR_MTVAL,
            priv_pkg::CSR_MINSTRET: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // Strobes to operation
    always_comb begin
        if (!valid_write) begin
            csr_op = priv_pkg::CSR_NONE;
        end else if (swap) begin
            csr_op = priv_pkg::CSR_SWAP;
        end else if (set) begin
            csr_op = priv_pkg::CSR_SET;
        end else if (clr) begin
            csr_op = priv_pkg::CSR_CLEAR;
        end else begin
            csr_op = priv_pkg::CSR_NONE;
        end
    end

    assign invalid_csr = valid_write & (~known | (read_only & strobe));

    // Pipeline issues one CSR operation per instruction
    always_comb begin
        if (valid_write) begin
            assert ($onehot0({swap, set, clr}))
                else $error("more than one CSR strobe active");
        end
    end

endmodule

// File: verilog/priv_csr_file.sv
/*
 * Machine CSR file
 * Combinational read, read-modify-write, trap and mret updates
 */

`timescale 1ns/1ps

module priv_csr_file #(
    parameter logic [31:0] HART_ID     = 32'h0,
    parameter logic [31:0] MTVEC_RESET = 32'h100
) (
    input  logic                      CLK,
    input  logic                      reset,
    input  priv_pkg::csr_op_e         csr_op,
    input  priv_pkg::csr_addr_e       csr_sel,
    input  logic                      invalid_csr,
    input  logic [priv_pkg::XLEN-1:0] wdata,
    input  logic                      instr,
    input  logic                      wb_enable,
    input  logic                      timer_int,
    input  logic                      soft_int,
    input  logic                      ext_int,
    input  logic                      trap_take,
    input  priv_pkg::cause_e          trap_cause,
    input  logic                      trap_intr,
    input  logic [priv_pkg::XLEN-1:0] trap_epc,
    input  logic [priv_pkg::XLEN-1:0] trap_tval,
    input  logic                      mret_take,
    output logic [priv_pkg::XLEN-1:0] rdata,
    output logic                      mstatus_mie,
    output logic [priv_pkg::XLEN-1:0] mie_bits,
    output logic [priv_pkg::XLEN-1:0] mtvec_val,
    output logic [priv_pkg::XLEN-1:0] mepc_val
);

    // mstatus keeps only MIE and MPIE, the rest reads as zero
    logic                      mie_flag;
    logic                      mpie_flag;
    logic [priv_pkg::XLEN-1:0] mie_reg;
    logic [priv_pkg::XLEN-1:0] mtvec;
    logic [priv_pkg::XLEN-1:0] mscratch;
    logic [priv_pkg::XLEN-1:0] mepc;
    logic [priv_pkg::XLEN-1:0] mcause;
    logic [priv_pkg::XLEN-1:0] mtval;
    logic [priv_pkg::XLEN-1:0] minstret;
    logic [priv_pkg::XLEN-1:0] mstatus_word;
    logic [priv_pkg::XLEN-1:0] mip_word;
    logic [priv_pkg::XLEN-1:0] new_val;
    logic                      csr_we;

    always_comb begin
        mstatus_word = '0;
        mstatus_word[priv_pkg::MSTATUS_MIE]  = mie_flag;
        mstatus_word[priv_pkg::MSTATUS_MPIE] = mpie_flag;
    end

    // Pending bits follow the interrupt lines directly
    always_comb begin
        mip_word = '0;
        mip_word[priv_pkg::CAUSE_SOFT_INT]  = soft_int;
        mip_word[priv_pkg::CAUSE_TIMER_INT] = timer_int;
        mip_word[priv_pkg::CAUSE_EXT_INT]   = ext_int;
    end

    always_comb begin
        case (csr_sel)
            priv_pkg::CSR_MSTATUS:  rdata = mstatus_word;
            priv_pkg::CSR_MISA:     rdata = priv_pkg::MISA_VALUE;
            priv_pkg::CSR_MIE:      rdata = mie_reg;
            priv_pkg::CSR_MTVEC:    rdata = mtvec;
            priv_pkg::CSR_MSCRATCH: rdata = mscratch;
            priv_pkg::CSR_MEPC:     rdata = mepc;
            priv_pkg::CSR_MCAUSE:   rdata = mcause;
            priv_pkg::CSR_MTVAL:    rdata = mtval;
            priv_pkg::CSR_MIP:      rdata = mip_word;
            priv_pkg::CSR_MINSTRET: rdata = minstret;
            priv_pkg::CSR_MHARTID:  rdata = HART_ID;
            default:                rdata = '0;
        endcase
    end

    always_comb begin
        case (csr_op)
            priv_pkg::CSR_SWAP:  new_val = wdata;
            priv_pkg::CSR_SET:   new_val = rdata | wdata;
            priv_pkg::CSR_CLEAR: new_val = rdata & ~wdata;
            default:             new_val = rdata;
        endcase
    end

    // Traps and mret win over the software write
    assign csr_we = (csr_op != priv_pkg::CSR_NONE) & ~invalid_csr & ~trap_take & ~mret_take;

    always_ff @(posedge CLK) begin
        if (reset) begin
            mie_flag  <= 1'b0;
            mpie_flag <= 1'b0;
            mie_reg   <= '0;
            mtvec     <= MTVEC_RESET;
            mscratch  <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mtval     <= '0;
            minstret  <= '0;
        end else begin
            if (instr && wb_enable) begin
                minstret <= minstret + 1'b1;
            end
            if (trap_take) begin
                mepc      <= trap_epc;
                mcause    <= {trap_intr, {(priv_pkg::XLEN-5){1'b0}}, trap_cause};
                mtval     <= trap_tval;
                mpie_flag <= mie_flag;
                mie_flag  <= 1'b0;
            end else if (mret_take) begin
                mie_flag  <= mpie_flag;
                mpie_flag <= 1'b1;
            end else if (csr_we) begin
                case (csr_sel)
                    priv_pkg::CSR_MSTATUS: begin
                        mie_flag  <= new_val[priv_pkg::MSTATUS_MIE];
                        mpie_flag <= new_val[priv_pkg::MSTATUS_MPIE];
                    end
                    priv_pkg::CSR_MIE:      mie_reg  <= new_val;
                    priv_pkg::CSR_MTVEC:    mtvec    <= new_val;
                    priv_pkg::CSR_MSCRATCH: mscratch <= new_val;
                    priv_pkg::CSR_MEPC:     mepc     <= new_val;
                    priv_pkg::CSR_MCAUSE:   mcause   <= new_val;
                    priv_pkg::CSR_MTVAL:    mtval    <= new_val;
                    priv_pkg::CSR_MINSTRET: minstret <= new_val;
                    default: begin
                    end
                endcase
            end
        end
    end

    assign mstatus_mie = mie_flag;
    assign mie_bits    = mie_reg;
    assign mtvec_val   = mtvec;
    assign mepc_val    = mepc;

    // A rejected request leaves the software-visible state untouched
    a_invalid_no_write: assert property (@(posedge CLK) disable iff (reset)
        invalid_csr && !trap_take && !mret_take |=>
            $stable(mscratch) && $stable(mie_reg) && $stable(mtvec) && $stable(mie_flag));

endmodule

// File: verilog/priv_pkg.sv
/*
 * Machine-mode privileged unit definitions
 * Data width, CSR addresses, CSR operations, cause codes and mstatus fields
 */

package priv_pkg;

    localparam int XLEN = 32;

    // Supported machine CSRs
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_MINSTRET = 12'hB02,
        CSR_MHARTID  = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_SWAP  = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // Exception codes
    typedef enum logic [3:0] {
        CAUSE_MAL_INSN   = 4'd0,
        CAUSE_FAULT_INSN = 4'd1,
        CAUSE_ILLEGAL    = 4'd2,
        CAUSE_BREAKPOINT = 4'd3,
        CAUSE_MAL_L      = 4'd4,
        CAUSE_FAULT_L    = 4'd5,
        CAUSE_MAL_S      = 4'd6,
        CAUSE_FAULT_S    = 4'd7,
        CAUSE_ECALL_M    = 4'd11
    } cause_e;

    // Interrupt codes share the numbering, mcause bit 31 tells them apart
    localparam cause_e CAUSE_SOFT_INT  = cause_e'(4'd3);
    localparam cause_e CAUSE_TIMER_INT = cause_e'(4'd7);
    localparam cause_e CAUSE_EXT_INT   = cause_e'(4'd11);

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // MXL = 1 (32 bit), extension I
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

endpackage

// File: verilog/priv_trap_handler.sv
/*
 * Trap handler
 * Arbitrates exceptions, interrupts and mret and registers the redirect
 */

`timescale 1ns/1ps

module priv_trap_handler (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      mal_insn,
    input  logic                      fault_insn,
    input  logic                      illegal_insn,
    input  logic                      breakpoint,
    input  logic                      mal_l,
    input  logic                      fault_l,
    input  logic                      mal_s,
    input  logic                      fault_s,
    input  logic                      env,
    input  logic [priv_pkg::XLEN-1:0] epc,
    input  logic [priv_pkg::XLEN-1:0] badaddr,
    input  logic                      ret,
    input  logic                      timer_int,
    input  logic                      soft_int,
    input  logic                      ext_int,
    input  logic                      mstatus_mie,
    input  logic [priv_pkg::XLEN-1:0] mie_bits,
    input  logic [priv_pkg::XLEN-1:0] mtvec_val,
    input  logic [priv_pkg::XLEN-1:0] mepc_val,
    output logic                      trap_take,
    output priv_pkg::cause_e          trap_cause,
    output logic                      trap_intr,
    output logic [priv_pkg::XLEN-1:0] trap_epc,
    output logic [priv_pkg::XLEN-1:0] trap_tval,
    output logic                      mret_take,
    output logic [priv_pkg::XLEN-1:0] priv_pc,
    output logic                      insert_pc,
    output logic                      intr
);

    logic                      exc_any;
    priv_pkg::cause_e          exc_cause;
    logic                      ext_pend;
    logic                      soft_pend;
    logic                      timer_pend;
    logic                      int_any;
    priv_pkg::cause_e          int_cause;
    logic                      addr_cause;
    logic [priv_pkg::XLEN-1:0] base;
    logic [priv_pkg::XLEN-1:0] target;

    // Highest priority exception first
    always_comb begin
        exc_any   = 1'b1;
        exc_cause = priv_pkg::CAUSE_BREAKPOINT;
        if (breakpoint)        exc_cause = priv_pkg::CAUSE_BREAKPOINT;
        else if (fault_insn)   exc_cause = priv_pkg::CAUSE_FAULT_INSN;
        else if (mal_insn)     exc_cause = priv_pkg::CAUSE_MAL_INSN;
        else if (illegal_insn) exc_cause = priv_pkg::CAUSE_ILLEGAL;
        else if (env)          exc_cause = priv_pkg::CAUSE_ECALL_M;
        else if (mal_s)        exc_cause = priv_pkg::CAUSE_MAL_S;
        else if (mal_l)        exc_cause = priv_pkg::CAUSE_MAL_L;
        else if (fault_s)      exc_cause = priv_pkg::CAUSE_FAULT_S;
        else if (fault_l)      exc_cause = priv_pkg::CAUSE_FAULT_L;
        else                   exc_any   = 1'b0;
    end

    assign ext_pend   = ext_int & mie_bits[priv_pkg::CAUSE_EXT_INT];
    assign soft_pend  = soft_int & mie_bits[priv_pkg::CAUSE_SOFT_INT];
    assign timer_pend = timer_int & mie_bits[priv_pkg::CAUSE_TIMER_INT];
    assign int_any    = mstatus_mie & (ext_pend | soft_pend | timer_pend);
    assign int_cause  = ext_pend  ? priv_pkg::CAUSE_EXT_INT  :
                        soft_pend ? priv_pkg::CAUSE_SOFT_INT : priv_pkg::CAUSE_TIMER_INT;

    assign trap_take  = exc_any | int_any;
    assign trap_intr  = ~exc_any & int_any;
    assign trap_cause = exc_any ? exc_cause : int_cause;
    assign mret_take  = ret & ~trap_take;
    assign trap_epc   = epc;

    // Only address-related exceptions report badaddr
    assign addr_cause = exc_any & (exc_cause inside {priv_pkg::CAUSE_MAL_INSN,
        priv_pkg::CAUSE_FAULT_INSN, priv_pkg::CAUSE_MAL_L, priv_pkg::CAUSE_FAULT_L,
        priv_pkg::CAUSE_MAL_S, priv_pkg::CAUSE_FAULT_S});
    assign trap_tval  = addr_cause ? badaddr : '0;

    assign base = {mtvec_val[priv_pkg::XLEN-1:2], 2'b00};

    always_comb begin
        if (mret_take) begin
            target = mepc_val;
        end else if (trap_intr && mtvec_val[1:0] == 2'b01) begin
            target = base + {{(priv_pkg::XLEN-6){1'b0}}, trap_cause, 2'b00};
        end else begin
            target = base;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            insert_pc <= 1'b0;
            intr      <= 1'b0;
        end else begin
            insert_pc <= trap_take | mret_take;
            intr      <= trap_intr;
        end
    end

    always_ff @(posedge CLK) begin
        if (trap_take || mret_take) begin
            priv_pc <= target;
        end
    end

    // Redirect pulse only follows a taken trap or mret
    a_redirect_cause: assert property (@(posedge CLK) disable iff (reset)
        !(trap_take || mret_take) |=> !insert_pc);

endmodule
